//--- compile.f
src/fetch_pkg.sv
src/ex_resolve_if.sv
src/branch_predictor.sv
src/fetch_redirect.sv
src/pc_gen.sv
src/fetch_queue.sv
src/fetch_top.sv
test/fetch_asserts.sv
test/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module fetch_tb -f compile.f -o fetch_sim &&
./obj_dir/fetch_sim ||
{ echo "fetch simulation returned an error status" >&2; exit 1; }

//--- src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t pc,
    ex_resolve_if.dst        resolve,
    output logic             pred_taken_1,
    output fetch_pkg::addr_t pred_target_1,
    output logic             pred_taken_2,
    output fetch_pkg::addr_t pred_target_2
);
    import fetch_pkg::*;

    localparam int ENTRIES  = 1 << BHT_INDEX_BITS;
    localparam int TAG_BITS = 30 - BHT_INDEX_BITS;

    typedef logic [BHT_INDEX_BITS-1:0] bht_index_t;
    typedef logic [TAG_BITS-1:0]       bht_tag_t;
    typedef logic [1:0]                counter_t;

    counter_t   counter      [ENTRIES];
    logic       entry_valid  [ENTRIES];
    bht_tag_t   entry_tag    [ENTRIES];
    addr_t      entry_target [ENTRIES];

    addr_t      pc_2;
    bht_index_t idx_1;
    bht_index_t idx_2;
    bht_index_t upd_idx;
    logic       do_update;

    // Word address bits above the byte offset pick the entry, the rest form the tag
    function automatic bht_index_t index_of(addr_t addr);
        return addr[BHT_INDEX_BITS+1:2];
    endfunction

    function automatic bht_tag_t tag_of(addr_t addr);
        return addr[31:BHT_INDEX_BITS+2];
    endfunction

    assign pc_2  = pc + 32'd4;
    assign idx_1 = index_of(pc);
    assign idx_2 = index_of(pc_2);

    // Taken only on a tag hit with the counter in one of its two upper states
    assign pred_taken_1  = entry_valid[idx_1] && (entry_tag[idx_1] == tag_of(pc))
                           && counter[idx_1][1];
    assign pred_target_1 = entry_target[idx_1];

    assign pred_taken_2  = entry_valid[idx_2] && (entry_tag[idx_2] == tag_of(pc_2))
                           && counter[idx_2][1];
    assign pred_target_2 = entry_target[idx_2];

    assign do_update = resolve.valid && resolve.is_jmp;
    assign upd_idx   = index_of(resolve.pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counter[i]     <= 2'd1;
                entry_valid[i] <= 1'b0;
            end
        end else if (do_update) begin
            if (resolve.act_taken) begin
                if (counter[upd_idx] != 2'd3) begin
                    counter[upd_idx] <= counter[upd_idx] + 2'd1;
                end
                entry_valid[upd_idx] <= 1'b1;
            end else if (counter[upd_idx] != 2'd0) begin
                counter[upd_idx] <= counter[upd_idx] - 2'd1;
            end
        end
    end

    // Only a taken outcome carries a target worth keeping
    always_ff @(posedge clk) begin
        if (do_update && resolve.act_taken) begin
            entry_tag[upd_idx]    <= tag_of(resolve.pc);
            entry_target[upd_idx] <= resolve.act_target;
        end
    end

endmodule

//--- src/ex_resolve_if.sv
`timescale 1ns/1ps

interface ex_resolve_if;
    import fetch_pkg::*;

    logic  valid;
    addr_t pc;
    logic  is_jmp;
    logic  act_taken;
    addr_t act_target;
    logic  pred_taken;
    addr_t pred_target;

    modport src (
        output valid, pc, is_jmp, act_taken, act_target, pred_taken, pred_target
    );

    modport dst (
        input valid, pc, is_jmp, act_taken, act_target, pred_taken, pred_target
    );

endinterface

//--- src/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Major opcodes in bits 31:26 that change the flow of control
    localparam opcode_t SPECIAL = 6'b000000;
    localparam opcode_t REGIMM  = 6'b000001;
    localparam opcode_t J       = 6'b000010;
    localparam opcode_t JAL     = 6'b000011;
    localparam opcode_t BEQ     = 6'b000100;
    localparam opcode_t BNE     = 6'b000101;
    localparam opcode_t BLEZ    = 6'b000110;
    localparam opcode_t BGTZ    = 6'b000111;

    // Register jumps live under SPECIAL and are told apart by bits 5:0
    localparam funct_t JR   = 6'b001000;
    localparam funct_t JALR = 6'b001001;

    typedef enum logic [1:0] {
        NORMAL,
        FETCH_DS,
        FETCH_TARGET
    } redirect_state_e;

    // One queue entry, from the top bit down:
    // pc [96:65], inst [64:33], pred_taken [32], pred_target [31:0]
    typedef logic [96:0] fetch_entry_t;

endpackage

//--- src/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_queue,
    input  logic                    wr_en_1,
    input  fetch_pkg::fetch_entry_t wr_entry_1,
    input  logic                    wr_en_2,
    input  fetch_pkg::fetch_entry_t wr_entry_2,
    input  logic                    out_ready,
    output logic                    out_valid,
    output fetch_pkg::fetch_entry_t out_entry,
    output logic                    fifo_full
);
    import fetch_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [PTR_BITS:0]   count_t;

    fetch_entry_t mem [QUEUE_DEPTH];
    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    ptr_t         wr_ptr_2;
    count_t       count;
    count_t       wr_count;
    logic         do_read;

    assign out_valid = (count != '0);
    assign out_entry = mem[rd_ptr];
    assign do_read   = out_valid && out_ready;

    // Two free slots are needed so that a full pair never has to be split
    assign fifo_full = (count > count_t'(QUEUE_DEPTH - 2));

    // Slot 2 lands right behind slot 1 when both are written
    assign wr_ptr_2 = wr_ptr + ptr_t'(wr_en_1);
    assign wr_count = count_t'(wr_en_1) + count_t'(wr_en_2);

    always_ff @(posedge clk) begin
        if (wr_en_1) begin
            mem[wr_ptr] <= wr_entry_1;
        end
        if (wr_en_2) begin
            mem[wr_ptr_2] <= wr_entry_2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_queue) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(wr_count);
            if (do_read) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            count <= count + wr_count - count_t'(do_read);
        end
    end

endmodule

//--- src/fetch_redirect.sv
`timescale 1ns/1ps

module fetch_redirect (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t pc,
    input  fetch_pkg::inst_t inst_1,
    input  logic             inst_ok_1,
    input  fetch_pkg::inst_t inst_2,
    input  logic             inst_ok_2,
    input  logic             icache_stall,
    input  logic             fifo_full,
    input  logic             pred_taken_1,
    input  logic             pred_taken_2,
    input  fetch_pkg::addr_t pred_target_1,
    input  fetch_pkg::addr_t pred_target_2,
    ex_resolve_if.dst        resolve,
    output logic             fetch_ena,
    output fetch_pkg::addr_t fetch_target,
    output logic             flush_queue,
    output logic             wr_en_1,
    output logic             wr_en_2,
    output logic             wr_pred_taken_1,
    output logic             wr_pred_taken_2
);
    import fetch_pkg::*;

    redirect_state_e state;
    redirect_state_e next_state;
    addr_t           saved_target;
    addr_t           store_value;
    logic            store_target;
    logic            mispredict;
    logic            pred_dir_1;
    logic            pred_dir_2;

    function automatic logic is_jump(inst_t inst);
        opcode_t op;
        funct_t  fn;
        op = inst[31:26];
        fn = inst[5:0];
        return (op == BEQ) || (op == BNE) || (op == REGIMM) || (op == BGTZ)
               || (op == BLEZ) || (op == J) || (op == JAL)
               || ((op == SPECIAL) && ((fn == JR) || (fn == JALR)));
    endfunction

    assign mispredict = resolve.valid && resolve.is_jmp
                        && ((resolve.act_taken != resolve.pred_taken)
                            || (resolve.act_taken
                                && (resolve.act_target != resolve.pred_target)));

    assign pred_dir_1 = pred_taken_1 && inst_ok_1 && is_jump(inst_1);
    assign pred_dir_2 = pred_taken_2 && inst_ok_2 && is_jump(inst_2);

    // Slot 2 only goes in behind slot 1, and never outside NORMAL
    assign wr_en_1 = inst_ok_1 && !icache_stall && !fifo_full && !mispredict;
    assign wr_en_2 = wr_en_1 && inst_ok_2 && (state == NORMAL);

    always_comb begin
        next_state      = state;
        fetch_ena       = 1'b0;
        fetch_target    = '0;
        flush_queue     = 1'b0;
        store_target    = 1'b0;
        store_value     = pred_target_1;
        wr_pred_taken_1 = 1'b0;
        wr_pred_taken_2 = 1'b0;

        if (mispredict) begin
            fetch_ena    = 1'b1;
            flush_queue  = 1'b1;
            fetch_target = resolve.act_taken ? resolve.act_target : resolve.pc + 32'd8;
            next_state   = NORMAL;
        end else begin
            case (state)
                FETCH_DS: begin
                    // Slot 1 holds the delay slot here, the word behind it is dropped
                    if (wr_en_1) begin
                        fetch_ena    = 1'b1;
                        fetch_target = saved_target;
                        next_state   = FETCH_TARGET;
                    end
                end
                default: begin
                    if (wr_en_1) begin
                        next_state = NORMAL;
                        if (pred_dir_1 && wr_en_2) begin
                            // Delay slot came in the same pair
                            fetch_ena       = 1'b1;
                            fetch_target    = pred_target_1;
                            wr_pred_taken_1 = 1'b1;
                        end else if (pred_dir_1) begin
                            fetch_ena       = 1'b1;
                            fetch_target    = pc + 32'd4;
                            store_target    = 1'b1;
                            wr_pred_taken_1 = 1'b1;
                            next_state      = FETCH_DS;
                        end else if (pred_dir_2 && wr_en_2) begin
                            fetch_ena       = 1'b1;
                            fetch_target    = pc + 32'd8;
                            store_target    = 1'b1;
                            store_value     = pred_target_2;
                            wr_pred_taken_2 = 1'b1;
                            next_state      = FETCH_DS;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= NORMAL;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (store_target) begin
            saved_target <= store_value;
        end
    end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int QUEUE_DEPTH    = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    input  fetch_pkg::addr_t ex_pc,
    input  logic             ex_is_jmp,
    input  logic             ex_act_taken,
    input  fetch_pkg::addr_t ex_act_target,
    input  logic             ex_pred_taken,
    input  fetch_pkg::addr_t ex_pred_target,
    output fetch_pkg::addr_t imem_addr,
    input  fetch_pkg::inst_t inst_1,
    input  logic             inst_ok_1,
    input  fetch_pkg::inst_t inst_2,
    input  logic             inst_ok_2,
    input  logic             icache_stall,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::inst_t out_inst,
    output logic             out_pred_taken,
    output fetch_pkg::addr_t out_pred_target,
    input  logic             out_ready
);
    import fetch_pkg::*;

    addr_t        pc;
    addr_t        fetch_target;
    addr_t        pred_target_1;
    addr_t        pred_target_2;
    logic         pred_taken_1;
    logic         pred_taken_2;
    logic         fetch_ena;
    logic         flush_queue;
    logic         fifo_full;
    logic         wr_en_1;
    logic         wr_en_2;
    logic         wr_pred_taken_1;
    logic         wr_pred_taken_2;
    fetch_entry_t wr_entry_1;
    fetch_entry_t wr_entry_2;
    fetch_entry_t out_entry;

    ex_resolve_if resolve_bus ();

    assign resolve_bus.valid       = ex_valid;
    assign resolve_bus.pc          = ex_pc;
    assign resolve_bus.is_jmp      = ex_is_jmp;
    assign resolve_bus.act_taken   = ex_act_taken;
    assign resolve_bus.act_target  = ex_act_target;
    assign resolve_bus.pred_taken  = ex_pred_taken;
    assign resolve_bus.pred_target = ex_pred_target;

    assign imem_addr = pc;

    // A target only travels with an entry that was actually predicted taken
    assign wr_entry_1 = {pc, inst_1, wr_pred_taken_1,
                         wr_pred_taken_1 ? pred_target_1 : 32'd0};
    assign wr_entry_2 = {pc + 32'd4, inst_2, wr_pred_taken_2,
                         wr_pred_taken_2 ? pred_target_2 : 32'd0};

    assign out_pc          = out_entry[96:65];
    assign out_inst        = out_entry[64:33];
    assign out_pred_taken  = out_entry[32];
    assign out_pred_target = out_entry[31:0];

    branch_predictor #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) i_branch_predictor (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .resolve       (resolve_bus.dst),
        .pred_taken_1  (pred_taken_1),
        .pred_target_1 (pred_target_1),
        .pred_taken_2  (pred_taken_2),
        .pred_target_2 (pred_target_2)
    );

    fetch_redirect i_fetch_redirect (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .inst_1          (inst_1),
        .inst_ok_1       (inst_ok_1),
        .inst_2          (inst_2),
        .inst_ok_2       (inst_ok_2),
        .icache_stall    (icache_stall),
        .fifo_full       (fifo_full),
        .pred_taken_1    (pred_taken_1),
        .pred_taken_2    (pred_taken_2),
        .pred_target_1   (pred_target_1),
        .pred_target_2   (pred_target_2),
        .resolve         (resolve_bus.dst),
        .fetch_ena       (fetch_ena),
        .fetch_target    (fetch_target),
        .flush_queue     (flush_queue),
        .wr_en_1         (wr_en_1),
        .wr_en_2         (wr_en_2),
        .wr_pred_taken_1 (wr_pred_taken_1),
        .wr_pred_taken_2 (wr_pred_taken_2)
    );

    pc_gen i_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .fetch_ena    (fetch_ena),
        .fetch_target (fetch_target),
        .wr_en_1      (wr_en_1),
        .wr_en_2      (wr_en_2),
        .pc           (pc)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_queue (flush_queue),
        .wr_en_1     (wr_en_1),
        .wr_entry_1  (wr_entry_1),
        .wr_en_2     (wr_en_2),
        .wr_entry_2  (wr_entry_2),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_entry   (out_entry),
        .fifo_full   (fifo_full)
    );

endmodule

//--- src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_ena,
    input  fetch_pkg::addr_t fetch_target,
    input  logic             wr_en_1,
    input  logic             wr_en_2,
    output fetch_pkg::addr_t pc
);
    import fetch_pkg::*;

    addr_t pc_step;

    // The PC moves past exactly the words that went into the queue
    always_comb begin
        if (wr_en_1 && wr_en_2) begin
            pc_step = 32'd8;
        end else if (wr_en_1) begin
            pc_step = 32'd4;
        end else begin
            pc_step = 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (fetch_ena) begin
            pc <= fetch_target;
        end else begin
            pc <= pc + pc_step;
        end
    end

endmodule

//--- test/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts #(
    parameter bit QUEUE_SIDE = 1'b1
) (
    input logic clk,
    input logic rst,
    input logic fifo_full,
    input logic wr_en_1,
    input logic wr_en_2,
    input logic flush_queue,
    input logic watch
);

    generate
        if (QUEUE_SIDE) begin : g_queue
            // Back-pressure has to hold both write ports low
            write_while_full: assert property (
                @(posedge clk) disable iff (rst) fifo_full |-> !(wr_en_1 || wr_en_2)
            ) else $error("write enable high while the fetch queue is full");

            // On the queue side watch is out_valid
            idle_after_reset: assert property (
                @(posedge clk) rst |=> !watch
            ) else $error("out_valid high on the cycle after reset");
        end else begin : g_redirect
            // On the redirect side watch is high while the FSM sits in NORMAL
            normal_after_flush: assert property (
                @(posedge clk) disable iff (rst) flush_queue |=> watch
            ) else $error("redirect FSM not back in NORMAL after a flush");
        end
    endgenerate

endmodule

bind fetch_queue fetch_asserts #(.QUEUE_SIDE(1'b1)) i_queue_asserts (
    .clk         (clk),
    .rst         (rst),
    .fifo_full   (fifo_full),
    .wr_en_1     (wr_en_1),
    .wr_en_2     (wr_en_2),
    .flush_queue (flush_queue),
    .watch       (out_valid)
);

bind fetch_redirect fetch_asserts #(.QUEUE_SIDE(1'b0)) i_redirect_asserts (
    .clk         (clk),
    .rst         (rst),
    .fifo_full   (fifo_full),
    .wr_en_1     (wr_en_1),
    .wr_en_2     (wr_en_2),
    .flush_queue (flush_queue),
    .watch       (state == fetch_pkg::NORMAL)
);

//--- test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int NUM_BRANCHES  = 3;
    localparam int NUM_SCENARIOS = 6;
    localparam addr_t RESET_PC   = 32'h0000_0000;

    typedef struct packed {
        logic  redirect;
        addr_t ex_pc;
        logic  act_taken;
        addr_t act_target;
        logic  pred_taken;
        addr_t pred_target;
        addr_t train_pc;
        addr_t train_target;
        int    train_count;
        int    count;
        logic  random_mode;
    } scenario_t;

    logic  clk;
    logic  rst;
    logic  ex_valid;
    addr_t ex_pc;
    logic  ex_is_jmp;
    logic  ex_act_taken;
    addr_t ex_act_target;
    logic  ex_pred_taken;
    addr_t ex_pred_target;
    addr_t imem_addr;
    inst_t inst_1;
    logic  inst_ok_1;
    inst_t inst_2;
    logic  inst_ok_2;
    logic  icache_stall;
    logic  out_valid;
    addr_t out_pc;
    inst_t out_inst;
    logic  out_pred_taken;
    addr_t out_pred_target;
    logic  out_ready;

    // Every word in this table is a conditional branch
    addr_t branch_pc   [NUM_BRANCHES] = '{32'h0000_0140, 32'h0000_0224, 32'h0000_0360};
    inst_t branch_word [NUM_BRANCHES] = '{32'h1000_0010, 32'h1420_0008, 32'h1c40_0004};

    scenario_t scenarios [NUM_SCENARIOS];
    int        model_count  [addr_t];
    logic      model_valid  [addr_t];
    addr_t     model_target [addr_t];
    addr_t     exp_pc     [$];
    logic      exp_taken  [$];
    addr_t     exp_target [$];

    fetch_top #(
        .BHT_INDEX_BITS (6),
        .QUEUE_DEPTH    (8)
    ) i_fetch_top (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_pc           (ex_pc),
        .ex_is_jmp       (ex_is_jmp),
        .ex_act_taken    (ex_act_taken),
        .ex_act_target   (ex_act_target),
        .ex_pred_taken   (ex_pred_taken),
        .ex_pred_target  (ex_pred_target),
        .imem_addr       (imem_addr),
        .inst_1          (inst_1),
        .inst_ok_1       (inst_ok_1),
        .inst_2          (inst_2),
        .inst_ok_2       (inst_ok_2),
        .icache_stall    (icache_stall),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_inst        (out_inst),
        .out_pred_taken  (out_pred_taken),
        .out_pred_target (out_pred_target),
        .out_ready       (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic is_branch_at(addr_t addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            if (branch_pc[i] == addr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Filler words are ADDI with an immediate folded from all address bits
    function automatic inst_t imem_word(addr_t addr);
        inst_t word;
        word = {6'b001000, addr[27:2] ^ {22'd0, addr[31:28]}};
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            if (branch_pc[i] == addr) begin
                word = branch_word[i];
            end
        end
        return word;
    endfunction

    function automatic logic predicted_taken(addr_t addr);
        if (!is_branch_at(addr) || !model_valid.exists(addr)) begin
            return 1'b0;
        end
        return model_count[addr] >= 2;
    endfunction

    task automatic model_update(addr_t pc, logic taken, addr_t target);
        int c;
        c = model_count.exists(pc) ? model_count[pc] : 1;
        if (taken) begin
            if (c < 3) begin
                c++;
            end
            model_valid[pc]  = 1'b1;
            model_target[pc] = target;
        end else if (c > 0) begin
            c--;
        end
        model_count[pc] = c;
    endtask

    // A predicted branch is followed by its delay slot and then its target
    task automatic build_expected(addr_t start, int count);
        addr_t a;
        exp_pc.delete();
        exp_taken.delete();
        exp_target.delete();
        a = start;
        while (exp_pc.size() < count) begin
            if (predicted_taken(a)) begin
                exp_pc.push_back(a);
                exp_taken.push_back(1'b1);
                exp_target.push_back(model_target[a]);
                exp_pc.push_back(a + 32'd4);
                exp_taken.push_back(1'b0);
                exp_target.push_back(32'd0);
                a = model_target[a];
            end else begin
                exp_pc.push_back(a);
                exp_taken.push_back(1'b0);
                exp_target.push_back(32'd0);
                a = a + 32'd4;
            end
        end
    endtask

    task automatic fail_run(string why);
        $display("Verification failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(string name, addr_t got, addr_t expected);
        if (got !== expected) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, expected);
            fail_run("address value mismatch");
        end
    endtask

    task automatic check_inst(string name, inst_t got, inst_t expected);
        if (got !== expected) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, expected);
            fail_run("instruction value mismatch");
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        if (got !== expected) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
            fail_run("flag value mismatch");
        end
    endtask

    // Memory answers for the pair at imem_addr, which only moves on a rising edge
    task automatic drive_imem(logic random_mode);
        inst_1       = imem_word(imem_addr);
        inst_2       = imem_word(imem_addr + 32'd4);
        inst_ok_1    = random_mode ? (($urandom % 8) != 0) : 1'b1;
        inst_ok_2    = random_mode ? (($urandom % 8) != 0) : 1'b1;
        icache_stall = random_mode ? (($urandom % 8) == 0) : 1'b0;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        ex_valid  = 1'b0;
        out_ready = 1'b0;
        drive_imem(1'b0);
    endtask

    task automatic send_resolve(addr_t pc, logic act_taken, addr_t act_target,
                                logic pred_taken, addr_t pred_target);
        @(negedge clk);
        ex_valid       = 1'b1;
        ex_pc          = pc;
        ex_is_jmp      = 1'b1;
        ex_act_taken   = act_taken;
        ex_act_target  = act_target;
        ex_pred_taken  = pred_taken;
        ex_pred_target = pred_target;
        out_ready      = 1'b0;
        drive_imem(1'b0);
        model_update(pc, act_taken, act_target);
    endtask

    // A transfer is decided at the falling edge and happens at the next rising edge
    task automatic collect_stream(int count, logic random_mode);
        int   got;
        int   cycles;
        logic ready;
        got    = 0;
        cycles = 0;
        while ((got < count) && (cycles < count * 8 + 64)) begin
            @(negedge clk);
            ex_valid  = 1'b0;
            ready     = random_mode ? (($urandom % 4) != 0) : 1'b1;
            out_ready = ready;
            drive_imem(random_mode);
            if (out_valid && ready) begin
                check_addr("out_pc", out_pc, exp_pc[got]);
                check_inst("out_inst", out_inst, imem_word(exp_pc[got]));
                check_bit("out_pred_taken", out_pred_taken, exp_taken[got]);
                if (exp_taken[got]) begin
                    check_addr("out_pred_target", out_pred_target, exp_target[got]);
                end
                got++;
            end
            cycles++;
        end
        if (got < count) begin
            fail_run("timeout while waiting for entries from the fetch queue");
        end
    endtask

    task automatic run_scenario(scenario_t sc);
        addr_t start;
        // Decode stalls while the queue fills up behind it
        repeat (4) idle_cycle();
        for (int t = 0; t < sc.train_count; t++) begin
            send_resolve(sc.train_pc, 1'b1, sc.train_target, 1'b1, sc.train_target);
            idle_cycle();
        end
        if (sc.redirect) begin
            send_resolve(sc.ex_pc, sc.act_taken, sc.act_target, sc.pred_taken, sc.pred_target);
            start = sc.act_taken ? sc.act_target : sc.ex_pc + 32'd8;
        end else begin
            start = RESET_PC;
        end
        build_expected(start, sc.count);
        collect_stream(sc.count, sc.random_mode);
    endtask

    task automatic fill_scenarios();
        scenarios[0] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0,
                         32'h0, 32'h0, 0, 12, 1'b0};
        scenarios[1] = '{1'b1, 32'h0001_0000, 1'b1, 32'h0000_0130, 1'b0, 32'h0,
                         32'h0000_0140, 32'h0000_0400, 2, 16, 1'b0};
        scenarios[2] = '{1'b1, 32'h0001_0000, 1'b1, 32'h0000_0210, 1'b0, 32'h0,
                         32'h0000_0224, 32'h0000_0500, 2, 14, 1'b0};
        scenarios[3] = '{1'b1, 32'h0000_0360, 1'b0, 32'h0, 1'b1, 32'h0000_0600,
                         32'h0, 32'h0, 0, 10, 1'b0};
        scenarios[4] = '{1'b1, 32'h0001_0000, 1'b1, 32'h0000_0120, 1'b1, 32'h0000_0300,
                         32'h0, 32'h0, 0, 40, 1'b1};
        scenarios[5] = '{1'b1, 32'h0001_0000, 1'b1, 32'h0000_0200, 1'b0, 32'h0,
                         32'h0, 32'h0, 0, 60, 1'b1};
    endtask

    initial begin
        rst            = 1'b1;
        ex_valid       = 1'b0;
        ex_pc          = '0;
        ex_is_jmp      = 1'b0;
        ex_act_taken   = 1'b0;
        ex_act_target  = '0;
        ex_pred_taken  = 1'b0;
        ex_pred_target = '0;
        inst_1         = '0;
        inst_ok_1      = 1'b0;
        inst_2         = '0;
        inst_ok_2      = 1'b0;
        icache_stall   = 1'b0;
        out_ready      = 1'b0;
        void'($urandom(32'h8d3a12ab));
        fill_scenarios();

        repeat (10) idle_cycle();
        rst = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_addr("imem_addr", imem_addr, RESET_PC);

        for (int s = 0; s < NUM_SCENARIOS; s++) begin
            run_scenario(scenarios[s]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule
